//--- verilog/stream_pe_macros.svh
`ifndef STREAM_PE_MACROS_SVH
`define STREAM_PE_MACROS_SVH

// datapath width of one phit
`define PHIT_W 32

// processing-element columns in the chain
`define NUM_COL 3

// configuration table geometry
`define CFG_DEPTH 16
`define CFG_AW 4

// per-column register file geometry
`define RF_DEPTH 16
`define RF_AW 4

// item counter width, wraps at 256
`define ITR_W 8

`endif

//--- verilog/stream_pe_pkg.sv
`default_nettype none

`include "stream_pe_macros.svh"

package stream_pe_pkg;

    // alu opcode, all arithmetic wraps modulo 2^32
    typedef enum logic [1:0] {
        OP_PASS = 2'd0,
        OP_ADD  = 2'd1,
        OP_XOR  = 2'd2,
        OP_SUB  = 2'd3
    } pe_op_t;

    // source of operand b
    typedef enum logic [1:0] {
        SEL_IMM     = 2'd0,
        SEL_INBOUND = 2'd1,
        SEL_RF      = 2'd2,
        SEL_ITR     = 2'd3
    } opb_sel_t;

    // one column's control word, 9 bits
    typedef struct packed {
        pe_op_t             op;
        opb_sel_t           opb_sel;
        logic               wen;
        logic [`RF_AW-1:0]  rf_addr;
    } col_ctrl_t;

    // full table entry, one control word and one immediate per column
    typedef struct packed {
        col_ctrl_t [`NUM_COL-1:0]          ctrl;
        logic [`NUM_COL-1:0][`PHIT_W-1:0]  imm;
    } cfg_entry_t;

endpackage

`default_nettype wire

//--- verilog/col_ctrl_if.sv
`default_nettype none

`include "stream_pe_macros.svh"

// link between two pipeline stages
interface col_ctrl_if;

    // produced by the upstream stage
    logic                       valid;
    logic [`PHIT_W-1:0]         data;
    logic [`PHIT_W-1:0]         inbound;
    logic [`ITR_W-1:0]          itr;

    // config of the downstream column, filled in by the top level
    stream_pe_pkg::col_ctrl_t   ctrl;
    logic [`PHIT_W-1:0]         imm;

    modport src (
        output valid,
        output data,
        output inbound,
        output itr
    );

    modport dst (
        input valid,
        input data,
        input inbound,
        input itr,
        input ctrl,
        input imm
    );

endinterface

`default_nettype wire

//--- verilog/config_table.sv
`default_nettype none

`include "stream_pe_macros.svh"

module config_table (
    input  wire logic                       clk,
    input  wire logic [`CFG_AW-1:0]         wr_addr,
    input  wire logic [`NUM_COL-1:0]        wr_col_en,
    input  wire stream_pe_pkg::col_ctrl_t   wr_ctrl,
    input  wire logic [`PHIT_W-1:0]         wr_imm,
    input  wire logic [`CFG_AW-1:0]         rd_addr,
    output stream_pe_pkg::cfg_entry_t       rd_entry
);

    // one control array and one immediate array per column
    stream_pe_pkg::col_ctrl_t   ctrl_mem [`NUM_COL][`CFG_DEPTH];
    logic [`PHIT_W-1:0]         imm_mem  [`NUM_COL][`CFG_DEPTH];

    // writes land on the edge, a read on the same edge still sees the old entry
    always_ff @(posedge clk) begin
        for (int c = 0; c < `NUM_COL; c++) begin
            if (wr_col_en[c]) begin
                ctrl_mem[c][wr_addr] <= wr_ctrl;
                imm_mem[c][wr_addr]  <= wr_imm;
            end
        end
    end

    // registered read, entry lines up with the decoded phit
    always_ff @(posedge clk) begin
        for (int c = 0; c < `NUM_COL; c++) begin
            rd_entry.ctrl[c] <= ctrl_mem[c][rd_addr];
            rd_entry.imm[c]  <= imm_mem[c][rd_addr];
        end
    end

    // host must present a real address with any column enable
    a_wr_addr_known: assert property (
        @(posedge clk) (|wr_col_en) |-> !$isunknown(wr_addr)
    ) else $error("config_table write with unknown address");

endmodule

`default_nettype wire

//--- verilog/ctrl_decode.sv
`default_nettype none

`include "stream_pe_macros.svh"

module ctrl_decode (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               in_valid,
    input  wire logic [`PHIT_W-1:0]                 stream_in,
    input  wire logic [`PHIT_W-1:0]                 inbound,
    input  wire logic [`CFG_AW-1:0]                 rd_addr,
    input  wire stream_pe_pkg::cfg_entry_t          rd_entry,
    col_ctrl_if.src                                 stage0,
    output stream_pe_pkg::col_ctrl_t [`NUM_COL-1:0] entry_ctrl,
    output logic [`NUM_COL-1:0][`PHIT_W-1:0]        entry_imm,
    output logic [`CFG_AW-1:0]                      entry_idx
);

    logic [`ITR_W-1:0] item_cnt;

    // valid and the item counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage0.valid <= 1'b0;
            item_cnt     <= '0;
        end else begin
            stage0.valid <= in_valid;
            if (in_valid) begin
                item_cnt <= item_cnt + `ITR_W'(1);
            end
        end
    end

    // phit payload sampled alongside the table read
    always_ff @(posedge clk) begin
        stage0.data    <= stream_in;
        stage0.inbound <= inbound;
        // tag with the count before it advances
        stage0.itr     <= item_cnt;
        entry_idx      <= rd_addr;
    end

    // unpack the entry into per-column fields
    always_comb begin
        for (int c = 0; c < `NUM_COL; c++) begin
            entry_ctrl[c] = rd_entry.ctrl[c];
            entry_imm[c]  = rd_entry.imm[c];
        end
    end

endmodule

`default_nettype wire

//--- verilog/delay_pipe.sv
`default_nettype none

module delay_pipe #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire payload_t d,
    output payload_t    q
);

    if (DEPTH == 0) begin : g_wire
        // no delay needed for the first column
        assign q = d;
    end else begin : g_regs
        payload_t pipe_q [DEPTH];

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                for (int i = 0; i < DEPTH; i++) begin
                    pipe_q[i] <= '0;
                end
            end else begin
                pipe_q[0] <= d;
                for (int i = 1; i < DEPTH; i++) begin
                    pipe_q[i] <= pipe_q[i-1];
                end
            end
        end

        // oldest stage
        assign q = pipe_q[DEPTH-1];
    end

endmodule

`default_nettype wire

//--- verilog/pe_column.sv
`default_nettype none

`include "stream_pe_macros.svh"

module pe_column (
    input  wire logic   clk,
    input  wire logic   rst_n,
    col_ctrl_if.dst     up,
    col_ctrl_if.src     dn
);

    logic [`PHIT_W-1:0] rf [`RF_DEPTH];
    logic [`PHIT_W-1:0] rf_word;
    logic [`PHIT_W-1:0] opb;
    logic [`PHIT_W-1:0] result;

    // same address for read and write, read sees the old word
    assign rf_word = rf[up.ctrl.rf_addr];

    // operand b mux
    always_comb begin
        unique case (up.ctrl.opb_sel)
            stream_pe_pkg::SEL_IMM:     opb = up.imm;
            stream_pe_pkg::SEL_INBOUND: opb = up.inbound;
            stream_pe_pkg::SEL_RF:      opb = rf_word;
            stream_pe_pkg::SEL_ITR:     opb = {{(`PHIT_W - `ITR_W){1'b0}}, up.itr};
            default:                    opb = '0;
        endcase
    end

    // alu, operand a is the incoming data
    always_comb begin
        unique case (up.ctrl.op)
            stream_pe_pkg::OP_PASS: result = up.data;
            stream_pe_pkg::OP_ADD:  result = up.data + opb;
            stream_pe_pkg::OP_XOR:  result = up.data ^ opb;
            stream_pe_pkg::OP_SUB:  result = up.data - opb;
            default:                result = up.data;
        endcase
    end

    // valid bit and register file
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dn.valid <= 1'b0;
            for (int r = 0; r < `RF_DEPTH; r++) begin
                rf[r] <= '0;
            end
        end else begin
            dn.valid <= up.valid;
            if (up.valid && up.ctrl.wen) begin
                rf[up.ctrl.rf_addr] <= result;
            end
        end
    end

    // payload to the next stage
    always_ff @(posedge clk) begin
        dn.data    <= result;
        dn.inbound <= up.inbound;
        dn.itr     <= up.itr;
    end

    // delayed table control must be settled when an item reaches this column
    a_ctrl_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        up.valid |-> !$isunknown(up.ctrl)
    ) else $error("pe_column got a valid item with unknown control");

endmodule

`default_nettype wire

//--- verilog/stream_result.sv
`default_nettype none

`include "stream_pe_macros.svh"

module stream_result (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    col_ctrl_if.dst                         last,
    input  wire logic [`CFG_AW-1:0]         entry_idx,
    output logic                            out_valid,
    output logic [`PHIT_W-1:0]              stream_out,
    output logic [`ITR_W+`CFG_AW-1:0]       rd_data_state
);

    // strobe and state word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid     <= 1'b0;
            rd_data_state <= '0;
        end else begin
            out_valid <= last.valid;
            // count in the upper bits and the entry below
            if (last.valid) begin
                rd_data_state <= {last.itr, entry_idx};
            end
        end
    end

    // output data holds its last value while idle
    always_ff @(posedge clk) begin
        if (last.valid) begin
            stream_out <= last.data;
        end
    end

    // a delivered item carries known data and state
    a_out_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> !$isunknown({stream_out, rd_data_state})
    ) else $error("stream_result delivered an unknown output");

endmodule

`default_nettype wire

//--- verilog/stream_pe_top.sv
`default_nettype none

`include "stream_pe_macros.svh"

module stream_pe_top (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       in_valid,
    input  wire logic [`PHIT_W-1:0]         stream_in,
    input  wire logic [`PHIT_W-1:0]         inbound,
    input  wire logic [`CFG_AW-1:0]         rd_addr,
    input  wire logic [`CFG_AW-1:0]         wr_addr,
    input  wire logic [`NUM_COL-1:0]        wr_col_en,
    input  wire stream_pe_pkg::col_ctrl_t   wr_ctrl,
    input  wire logic [`PHIT_W-1:0]         wr_imm,
    output logic                            out_valid,
    output logic [`PHIT_W-1:0]              stream_out,
    output logic [`ITR_W+`CFG_AW-1:0]       rd_data_state
);

    // control word and immediate of one column, delayed together
    typedef struct packed {
        stream_pe_pkg::col_ctrl_t   ctrl;
        logic [`PHIT_W-1:0]         imm;
    } col_cfg_t;

    stream_pe_pkg::cfg_entry_t              rd_entry;
    stream_pe_pkg::col_ctrl_t [`NUM_COL-1:0] entry_ctrl;
    logic [`NUM_COL-1:0][`PHIT_W-1:0]       entry_imm;
    logic [`CFG_AW-1:0]                     entry_idx;
    logic [`CFG_AW-1:0]                     entry_idx_d;
    col_cfg_t [`NUM_COL-1:0]                cfg_now;
    col_cfg_t [`NUM_COL-1:0]                cfg_aligned;

    col_ctrl_if link [`NUM_COL+1] ();

    config_table u_config_table (
        .clk(clk), .wr_addr(wr_addr), .wr_col_en(wr_col_en), .wr_ctrl(wr_ctrl),
        .wr_imm(wr_imm), .rd_addr(rd_addr), .rd_entry(rd_entry)
    );

    ctrl_decode u_ctrl_decode (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .stream_in(stream_in),
        .inbound(inbound), .rd_addr(rd_addr), .rd_entry(rd_entry), .stage0(link[0]),
        .entry_ctrl(entry_ctrl), .entry_imm(entry_imm), .entry_idx(entry_idx)
    );

    for (genvar k = 0; k < `NUM_COL; k++) begin : g_col
        assign cfg_now[k] = {entry_ctrl[k], entry_imm[k]};

        // column k sees its item k cycles after decode
        delay_pipe #(.payload_t(col_cfg_t), .DEPTH(k)) u_cfg_pipe (
            .clk(clk), .rst_n(rst_n), .d(cfg_now[k]), .q(cfg_aligned[k])
        );

        assign link[k].ctrl = cfg_aligned[k].ctrl;
        assign link[k].imm  = cfg_aligned[k].imm;

        pe_column u_pe (.clk(clk), .rst_n(rst_n), .up(link[k]), .dn(link[k+1]));
    end

    // no column reads the last link's config
    assign link[`NUM_COL].ctrl = '0;
    assign link[`NUM_COL].imm  = '0;

    delay_pipe #(.payload_t(logic [`CFG_AW-1:0]), .DEPTH(`NUM_COL)) u_idx_pipe (
        .clk(clk), .rst_n(rst_n), .d(entry_idx), .q(entry_idx_d)
    );

    stream_result u_result (
        .clk(clk), .rst_n(rst_n), .last(link[`NUM_COL]), .entry_idx(entry_idx_d),
        .out_valid(out_valid), .stream_out(stream_out), .rd_data_state(rd_data_state)
    );

endmodule

`default_nettype wire

//--- dv/stream_pe_tb.sv
`default_nettype none

`include "stream_pe_macros.svh"

module stream_pe_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                           clk = 1'b0;
    logic                           rst_n;
    logic                           in_valid;
    logic [`PHIT_W-1:0]             stream_in;
    logic [`PHIT_W-1:0]             inbound;
    logic [`CFG_AW-1:0]             rd_addr;
    logic [`CFG_AW-1:0]             wr_addr;
    logic [`NUM_COL-1:0]            wr_col_en;
    stream_pe_pkg::col_ctrl_t       wr_ctrl;
    logic [`PHIT_W-1:0]             wr_imm;
    logic                           out_valid;
    logic [`PHIT_W-1:0]             stream_out;
    logic [`ITR_W+`CFG_AW-1:0]      rd_data_state;

    // reference copies of the table and the register files
    stream_pe_pkg::col_ctrl_t       tbl_ctrl [`NUM_COL][`CFG_DEPTH];
    logic [`PHIT_W-1:0]             tbl_imm  [`NUM_COL][`CFG_DEPTH];
    logic [`PHIT_W-1:0]             rf_model [`NUM_COL][`RF_DEPTH];
    logic [`ITR_W-1:0]              itr_cnt;
    logic [`PHIT_W-1:0]             exp_data_q [$];
    logic [`ITR_W+`CFG_AW-1:0]      exp_state_q [$];
    logic [`ITR_W+`CFG_AW-1:0]      held_state;
    int                             errors;
    int                             checks;
    int unsigned                    seed;

    stream_pe_top uut (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("tests failed");
        $finish;
    endtask

    function automatic stream_pe_pkg::col_ctrl_t make_ctrl(input stream_pe_pkg::pe_op_t op_v,
            input stream_pe_pkg::opb_sel_t sel_v, input logic wen_v,
            input logic [`RF_AW-1:0] addr_v);
        return '{op: op_v, opb_sel: sel_v, wen: wen_v, rf_addr: addr_v};
    endfunction

    // write one column of one entry for items sampled on the next edge
    task automatic write_cfg(input logic [`CFG_AW-1:0] addr, input int col,
            input stream_pe_pkg::col_ctrl_t cw, input logic [`PHIT_W-1:0] imm);
        wr_addr = addr;
        wr_col_en = '0;
        wr_col_en[col] = 1'b1;
        wr_ctrl = cw;
        wr_imm = imm;
        tbl_ctrl[col][addr] = cw;
        tbl_imm[col][addr] = imm;
        @(negedge clk);
        wr_col_en = '0;
    endtask

    task automatic write_all(input logic [`CFG_AW-1:0] addr, input stream_pe_pkg::pe_op_t op,
            input stream_pe_pkg::opb_sel_t sel);
        for (int c = 0; c < `NUM_COL; c++) begin
            write_cfg(addr, c, make_ctrl(op, sel, 1'b0, '0), $urandom());
        end
    endtask

    // model the item through all columns and drive it for one cycle
    task automatic issue_item(input logic [`CFG_AW-1:0] addr, input logic [`PHIT_W-1:0] data,
            input logic [`PHIT_W-1:0] inb);
        stream_pe_pkg::col_ctrl_t cw;
        logic [`PHIT_W-1:0] a;
        logic [`PHIT_W-1:0] b;
        a = data;
        for (int c = 0; c < `NUM_COL; c++) begin
            cw = tbl_ctrl[c][addr];
            case (cw.opb_sel)
                stream_pe_pkg::SEL_IMM:     b = tbl_imm[c][addr];
                stream_pe_pkg::SEL_INBOUND: b = inb;
                stream_pe_pkg::SEL_RF:      b = rf_model[c][cw.rf_addr];
                default:                    b = {{(`PHIT_W-`ITR_W){1'b0}}, itr_cnt};
            endcase
            case (cw.op)
                stream_pe_pkg::OP_ADD: a = a + b;
                stream_pe_pkg::OP_XOR: a = a ^ b;
                stream_pe_pkg::OP_SUB: a = a - b;
                default:               a = a;
            endcase
            // old word is read above and the new word stored after
            if (cw.wen) begin
                rf_model[c][cw.rf_addr] = a;
            end
        end
        exp_data_q.push_back(a);
        exp_state_q.push_back({itr_cnt, addr});
        itr_cnt++;
        in_valid = 1'b1;
        rd_addr = addr;
        stream_in = data;
        inbound = inb;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drain_outputs();
        int cycles;
        cycles = 0;
        while (exp_data_q.size() != 0 && cycles < 64) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_data_q.size() != 0) begin
            abort_run("output never arrived");
        end
    endtask

    // compares every output against the queued model results
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("error at %0t ns: output seen with no item outstanding", $time);
            end else begin
                held_state = exp_state_q.pop_front();
                check("stream_out", stream_out, exp_data_q.pop_front());
                check("rd_data_state", 32'(rd_data_state), 32'(held_state));
            end
        end else if (rst_n) begin
            // state word keeps the last item's value while idle
            check("rd_data_state held", 32'(rd_data_state), 32'(held_state));
        end
    end

    task automatic test_reset_pass();
        int cycles;
        write_all(4'd2, stream_pe_pkg::OP_PASS, stream_pe_pkg::SEL_IMM);
        check("out_valid idle after reset", 32'(out_valid), 32'd0);
        issue_item(4'd2, $urandom(), $urandom());
        cycles = 1;
        while (!out_valid && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!out_valid) begin
            abort_run("pass-through output never arrived");
        end else begin
            check("latency in cycles", 32'(cycles), 32'd5);
            drain_outputs();
        end
    endtask

    task automatic run_op(input stream_pe_pkg::pe_op_t op, input stream_pe_pkg::opb_sel_t sel);
        write_all(4'd3, op, sel);
        repeat (3) issue_item(4'd3, $urandom(), $urandom());
        drain_outputs();
    endtask

    task automatic test_regfile();
        write_cfg(4'd4, 0, make_ctrl(stream_pe_pkg::OP_ADD, stream_pe_pkg::SEL_IMM, 1'b1, 4'd3),
                  $urandom());
        write_cfg(4'd4, 1, make_ctrl(stream_pe_pkg::OP_PASS, stream_pe_pkg::SEL_IMM, 1'b0, 4'd0),
                  $urandom());
        write_cfg(4'd4, 2, make_ctrl(stream_pe_pkg::OP_XOR, stream_pe_pkg::SEL_IMM, 1'b1, 4'd7),
                  $urandom());
        write_cfg(4'd5, 0, make_ctrl(stream_pe_pkg::OP_SUB, stream_pe_pkg::SEL_RF, 1'b0, 4'd3),
                  $urandom());
        write_cfg(4'd5, 1, make_ctrl(stream_pe_pkg::OP_ADD, stream_pe_pkg::SEL_IMM, 1'b0, 4'd0),
                  $urandom());
        write_cfg(4'd5, 2, make_ctrl(stream_pe_pkg::OP_ADD, stream_pe_pkg::SEL_RF, 1'b0, 4'd7),
                  $urandom());
        write_all(4'd6, stream_pe_pkg::OP_PASS, stream_pe_pkg::SEL_IMM);
        // each item adds the word left by the one before
        write_cfg(4'd6, 1, make_ctrl(stream_pe_pkg::OP_ADD, stream_pe_pkg::SEL_RF, 1'b1, 4'd2),
                  $urandom());
        issue_item(4'd4, $urandom(), $urandom());
        drain_outputs();
        issue_item(4'd5, $urandom(), $urandom());
        drain_outputs();
        repeat (3) issue_item(4'd6, $urandom(), $urandom());
        repeat (2) begin
            issue_item(4'd4, $urandom(), $urandom());
            issue_item(4'd5, $urandom(), $urandom());
        end
        drain_outputs();
    endtask

    task automatic test_itr_stream();
        logic [`CFG_AW-1:0] e;
        for (e = 4'd8; e <= 4'd10; e++) begin
            write_cfg(e, 0, make_ctrl(stream_pe_pkg::OP_ADD, stream_pe_pkg::SEL_ITR, 1'b0, '0),
                      $urandom());
            write_cfg(e, 1, make_ctrl(stream_pe_pkg::OP_XOR, stream_pe_pkg::SEL_IMM, 1'b0, '0),
                      $urandom());
            write_cfg(e, 2, make_ctrl(stream_pe_pkg::OP_SUB, stream_pe_pkg::SEL_ITR, 1'b0, '0),
                      $urandom());
        end
        // long enough for the item count to wrap
        e = 4'd8;
        repeat (270) begin
            issue_item(e, $urandom(), $urandom());
            e = (e == 4'd10) ? 4'd8 : e + 4'd1;
        end
        drain_outputs();
    endtask

    task automatic test_table_rewrite();
        write_all(4'd12, stream_pe_pkg::OP_ADD, stream_pe_pkg::SEL_IMM);
        issue_item(4'd12, $urandom(), $urandom());
        write_cfg(4'd12, 1, make_ctrl(stream_pe_pkg::OP_XOR, stream_pe_pkg::SEL_IMM, 1'b0, '0),
                  $urandom());
        issue_item(4'd12, $urandom(), $urandom());
        write_cfg(4'd12, 0, make_ctrl(stream_pe_pkg::OP_SUB, stream_pe_pkg::SEL_INBOUND, 1'b0,
                  '0), $urandom());
        repeat (2) issue_item(4'd12, $urandom(), $urandom());
        drain_outputs();
    endtask

    initial begin
        seed = $urandom(32'h2eec);
        rst_n = 1'b0;
        in_valid = 1'b0;
        stream_in = '0;
        inbound = '0;
        rd_addr = '0;
        wr_addr = '0;
        wr_col_en = '0;
        wr_ctrl = '0;
        wr_imm = '0;
        itr_cnt = '0;
        held_state = '0;
        errors = 0;
        checks = 0;
        for (int c = 0; c < `NUM_COL; c++) begin
            for (int r = 0; r < `RF_DEPTH; r++) begin
                rf_model[c][r] = '0;
            end
        end
        repeat (5) begin
            @(negedge clk);
            check("out_valid in reset", 32'(out_valid), 32'd0);
        end
        rst_n = 1'b1;
        test_reset_pass();
        run_op(stream_pe_pkg::OP_PASS, stream_pe_pkg::SEL_IMM);
        run_op(stream_pe_pkg::OP_ADD, stream_pe_pkg::SEL_IMM);
        run_op(stream_pe_pkg::OP_XOR, stream_pe_pkg::SEL_IMM);
        run_op(stream_pe_pkg::OP_SUB, stream_pe_pkg::SEL_IMM);
        run_op(stream_pe_pkg::OP_ADD, stream_pe_pkg::SEL_INBOUND);
        run_op(stream_pe_pkg::OP_XOR, stream_pe_pkg::SEL_INBOUND);
        run_op(stream_pe_pkg::OP_SUB, stream_pe_pkg::SEL_INBOUND);
        test_regfile();
        test_itr_stream();
        test_table_rewrite();
        repeat (4) @(negedge clk);
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+verilog
verilog/stream_pe_pkg.sv
verilog/col_ctrl_if.sv
verilog/config_table.sv
verilog/ctrl_decode.sv
verilog/delay_pipe.sv
verilog/pe_column.sv
verilog/stream_result.sv
verilog/stream_pe_top.sv
dv/stream_pe_tb.sv

//--- run.sh
#!/bin/sh
# build and run the stream_pe testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module stream_pe_tb -f files.f -o stream_pe_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/stream_pe_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    echo "result: PASS"
    exit 0
fi
echo "result: FAIL"
exit 1
